//--- design/fir_acc_pkg.sv
package fir_acc_pkg;

  // datapath widths
  localparam int SAMPLE_W = 12;
  localparam int TAP_W    = 12;
  localparam int RESULT_W = 31;
  localparam int MAX_TAPS = 8;
  localparam int NTAPS_W  = 4;
  localparam int LEN_W    = 16;

  // result buffer
  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

  // apb side, word address comes from paddr[6:2]
  localparam int ADDR_W  = 12;
  localparam int WADDR_W = 5;

  localparam logic [WADDR_W-1:0] ADDR_SAMPLE = 5'd1;
  localparam logic [WADDR_W-1:0] ADDR_RESULT = 5'd2;
  localparam logic [WADDR_W-1:0] ADDR_COUNT  = 5'd4;
  localparam logic [WADDR_W-1:0] ADDR_STATUS = 5'd5;
  localparam logic [WADDR_W-1:0] ADDR_NTAPS  = 5'd6;
  // taps 0..7 sit at consecutive words 7..14
  localparam logic [WADDR_W-1:0] ADDR_TAP0   = 5'd7;
  localparam logic [WADDR_W-1:0] ADDR_LENGTH = 5'd16;

  localparam logic [31:0] UNMAPPED_READ = 32'hFFFF_FFFF;

  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    RUN   = 2'd1,
    DRAIN = 2'd2
  } seq_state_t;

endpackage

//--- design/fir_cfg_if.sv
`timescale 1ns/1ps

interface fir_cfg_if;

  logic [fir_acc_pkg::MAX_TAPS-1:0][fir_acc_pkg::TAP_W-1:0] taps;
  logic [fir_acc_pkg::NTAPS_W-1:0]                          ntaps;
  logic [fir_acc_pkg::LEN_W-1:0]                            length;
  logic [fir_acc_pkg::SAMPLE_W-1:0]                         sample;
  // one cycle per written sample
  logic                                                     sample_wr;

  modport src (output taps, output ntaps, output length, output sample, output sample_wr);

  modport core (input taps, input ntaps, input length, input sample, input sample_wr);

endinterface

//--- design/apb_fir_regs.sv
`timescale 1ns/1ps

module apb_fir_regs (
  input  logic                            i_clk,
  input  logic                            i_reset,
  input  logic [fir_acc_pkg::ADDR_W-1:0]  i_paddr,
  input  logic [31:0]                     i_pwdata,
  input  logic                            i_pwrite,
  input  logic                            i_psel,
  input  logic                            i_penable,
  input  logic [fir_acc_pkg::RESULT_W-1:0] i_fifo_data,
  input  logic                            i_fifo_empty,
  input  logic                            i_fifo_full,
  input  logic                            i_busy,
  output logic [31:0]                     o_prdata,
  output logic                            o_pop,
  fir_cfg_if.src                          cfg
);

  logic [fir_acc_pkg::WADDR_W-1:0]                          waddr;
  logic                                                     wr_access;
  logic                                                     rd_access;
  logic [fir_acc_pkg::MAX_TAPS-1:0][fir_acc_pkg::TAP_W-1:0] taps;
  logic [fir_acc_pkg::NTAPS_W-1:0]                          ntaps;
  logic [fir_acc_pkg::LEN_W-1:0]                            length;
  logic [fir_acc_pkg::SAMPLE_W-1:0]                         sample;
  logic                                                     sample_wr;
  logic [31:0]                                              count;

  // word addressed
  assign waddr     = i_paddr[fir_acc_pkg::WADDR_W+1:2];
  assign wr_access = i_psel & i_penable & i_pwrite;
  assign rd_access = i_psel & i_penable & ~i_pwrite;

  // head entry is on prdata in the same cycle, fifo advances at the edge
  assign o_pop = rd_access & (waddr == fir_acc_pkg::ADDR_RESULT);

  always_ff @(posedge i_clk or posedge i_reset)
  begin
    if (i_reset)
    begin
      taps      <= '0;
      ntaps     <= fir_acc_pkg::NTAPS_W'(fir_acc_pkg::MAX_TAPS);
      length    <= fir_acc_pkg::LEN_W'(1);
      count     <= '0;
      sample_wr <= 1'b0;
    end
    else
    begin
      sample_wr <= wr_access & (waddr == fir_acc_pkg::ADDR_SAMPLE);
      if (wr_access)
      begin
        case (waddr)
          fir_acc_pkg::ADDR_SAMPLE: count  <= count + 1'b1;
          fir_acc_pkg::ADDR_NTAPS:  ntaps  <= i_pwdata[fir_acc_pkg::NTAPS_W-1:0];
          fir_acc_pkg::ADDR_LENGTH: length <= i_pwdata[fir_acc_pkg::LEN_W-1:0];
          default: ;
        endcase
        for (int k = 0; k < fir_acc_pkg::MAX_TAPS; k++)
        begin
          if (waddr == fir_acc_pkg::ADDR_TAP0 + k)
            taps[k] <= i_pwdata[fir_acc_pkg::TAP_W-1:0];
        end
      end
    end
  end

  // sample payload, captured with the strobe
  always_ff @(posedge i_clk)
  begin
    if (wr_access && (waddr == fir_acc_pkg::ADDR_SAMPLE))
      sample <= i_pwdata[fir_acc_pkg::SAMPLE_W-1:0];
  end

  assign cfg.taps      = taps;
  assign cfg.ntaps     = ntaps;
  assign cfg.length    = length;
  assign cfg.sample    = sample;
  assign cfg.sample_wr = sample_wr;

  always_comb
  begin
    o_prdata = fir_acc_pkg::UNMAPPED_READ;
    case (waddr)
      fir_acc_pkg::ADDR_RESULT:
        o_prdata = {{(32-fir_acc_pkg::RESULT_W){i_fifo_data[fir_acc_pkg::RESULT_W-1]}},
                    i_fifo_data};
      fir_acc_pkg::ADDR_COUNT:  o_prdata = count;
      fir_acc_pkg::ADDR_STATUS: o_prdata = {29'd0, i_busy, i_fifo_full, i_fifo_empty};
      fir_acc_pkg::ADDR_NTAPS:  o_prdata = 32'(ntaps);
      fir_acc_pkg::ADDR_LENGTH: o_prdata = 32'(length);
      default: ;
    endcase
    // taps read back sign extended
    for (int k = 0; k < fir_acc_pkg::MAX_TAPS; k++)
    begin
      if (waddr == fir_acc_pkg::ADDR_TAP0 + k)
        o_prdata = {{(32-fir_acc_pkg::TAP_W){taps[k][fir_acc_pkg::TAP_W-1]}}, taps[k]};
    end
  end

endmodule

//--- design/fir_seq_fsm.sv
`timescale 1ns/1ps

module fir_seq_fsm (
  input  logic    i_clk,
  input  logic    i_reset,
  input  logic    i_input_done,
  input  logic    i_drain_done,
  output logic    o_ce,
  output logic    o_flush,
  output logic    o_busy,
  fir_cfg_if.core cfg
);

  fir_acc_pkg::seq_state_t state;
  fir_acc_pkg::seq_state_t state_nxt;

  always_ff @(posedge i_clk or posedge i_reset)
  begin
    if (i_reset)
      state <= fir_acc_pkg::IDLE;
    else
      state <= state_nxt;
  end

  always_comb
  begin
    state_nxt = state;
    case (state)
      fir_acc_pkg::IDLE, fir_acc_pkg::RUN:
      begin
        // a single tap needs no drain steps
        if (i_input_done)
          state_nxt = (cfg.ntaps == fir_acc_pkg::NTAPS_W'(1)) ? fir_acc_pkg::IDLE
                                                               : fir_acc_pkg::DRAIN;
        else if (cfg.sample_wr)
          state_nxt = fir_acc_pkg::RUN;
      end
      fir_acc_pkg::DRAIN:
      begin
        if (i_drain_done)
          state_nxt = fir_acc_pkg::IDLE;
      end
      default: state_nxt = fir_acc_pkg::IDLE;
    endcase
  end

  // one step per sample, then free running with zero samples
  assign o_flush = (state == fir_acc_pkg::DRAIN);
  assign o_ce    = o_flush | cfg.sample_wr;
  assign o_busy  = (state != fir_acc_pkg::IDLE);

endmodule

//--- design/fir_step_counter.sv
`timescale 1ns/1ps

module fir_step_counter (
  input  logic    i_clk,
  input  logic    i_reset,
  input  logic    i_ce,
  input  logic    i_flush,
  output logic    o_input_done,
  output logic    o_drain_done,
  fir_cfg_if.core cfg
);

  logic [fir_acc_pkg::LEN_W-1:0] count;
  logic [fir_acc_pkg::LEN_W-1:0] last_in;
  logic [fir_acc_pkg::LEN_W-1:0] last_drain;

  // last input step and last step of the whole convolution
  assign last_in    = cfg.length - 1'b1;
  assign last_drain = cfg.length + fir_acc_pkg::LEN_W'(cfg.ntaps) - fir_acc_pkg::LEN_W'(2);

  assign o_input_done = i_ce & ~i_flush & (count == last_in);
  // with one tap this lands on the last input step
  assign o_drain_done = i_ce & (count == last_drain);

  always_ff @(posedge i_clk or posedge i_reset)
  begin
    if (i_reset)
      count <= '0;
    else if (o_drain_done)
      count <= '0;
    else if (i_ce)
      count <= count + 1'b1;
  end

endmodule

//--- design/fir_tap_chain.sv
`timescale 1ns/1ps

module fir_tap_chain (
  input  logic                             i_clk,
  input  logic                             i_reset,
  input  logic                             i_ce,
  input  logic                             i_flush,
  output logic [fir_acc_pkg::RESULT_W-1:0] o_result,
  output logic                             o_valid,
  fir_cfg_if.core                          cfg
);

  localparam int PROD_W = fir_acc_pkg::SAMPLE_W + fir_acc_pkg::TAP_W;

  logic signed [fir_acc_pkg::SAMPLE_W-1:0] x;
  logic signed [fir_acc_pkg::TAP_W-1:0]    tap_eff [fir_acc_pkg::MAX_TAPS];
  logic signed [PROD_W-1:0]                prod    [fir_acc_pkg::MAX_TAPS];
  logic signed [fir_acc_pkg::RESULT_W-1:0] acc     [fir_acc_pkg::MAX_TAPS];
  logic                                    flush_q;
  logic                                    clear;

  // zero sample while draining
  assign x = i_flush ? '0 : cfg.sample;

  always_comb
  begin
    for (int k = 0; k < fir_acc_pkg::MAX_TAPS; k++)
    begin
      tap_eff[k] = (k < cfg.ntaps) ? cfg.taps[k] : '0;
      prod[k]    = tap_eff[k] * x;
    end
  end

  // end of drain, partial sums are dropped before the next run
  assign clear = flush_q & ~i_flush;

  always_ff @(posedge i_clk or posedge i_reset)
  begin
    if (i_reset)
    begin
      for (int k = 0; k < fir_acc_pkg::MAX_TAPS; k++)
        acc[k] <= '0;
      flush_q <= 1'b0;
      o_valid <= 1'b0;
    end
    else
    begin
      flush_q <= i_flush;
      o_valid <= i_ce;
      if (i_ce)
      begin
        acc[fir_acc_pkg::MAX_TAPS-1] <= prod[fir_acc_pkg::MAX_TAPS-1];
        for (int k = 0; k < fir_acc_pkg::MAX_TAPS-1; k++)
          acc[k] <= acc[k+1] + prod[k];
      end
      // stage 0 keeps the last result
      if (clear)
      begin
        for (int k = 1; k < fir_acc_pkg::MAX_TAPS; k++)
          acc[k] <= '0;
      end
    end
  end

  assign o_result = acc[0];

endmodule

//--- design/result_fifo.sv
`timescale 1ns/1ps

module result_fifo (
  input  logic                             i_clk,
  input  logic                             i_reset,
  input  logic                             i_push,
  input  logic [fir_acc_pkg::RESULT_W-1:0] i_data,
  input  logic                             i_pop,
  output logic [fir_acc_pkg::RESULT_W-1:0] o_data,
  output logic                             o_empty,
  output logic                             o_full
);

  logic [fir_acc_pkg::RESULT_W-1:0] mem [fir_acc_pkg::FIFO_DEPTH];

  // extra msb tells a full buffer from an empty one
  logic [fir_acc_pkg::FIFO_AW:0] wr_ptr;
  logic [fir_acc_pkg::FIFO_AW:0] rd_ptr;
  logic                          do_push;
  logic                          do_pop;

  assign o_empty = (wr_ptr == rd_ptr);
  assign o_full  = (wr_ptr[fir_acc_pkg::FIFO_AW] != rd_ptr[fir_acc_pkg::FIFO_AW]) &&
                   (wr_ptr[fir_acc_pkg::FIFO_AW-1:0] == rd_ptr[fir_acc_pkg::FIFO_AW-1:0]);

  // overflow drops the new entry
  assign do_push = i_push & ~o_full;
  assign do_pop  = i_pop & ~o_empty;

  assign o_data = mem[rd_ptr[fir_acc_pkg::FIFO_AW-1:0]];

  always_ff @(posedge i_clk or posedge i_reset)
  begin
    if (i_reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge i_clk)
  begin
    if (do_push)
      mem[wr_ptr[fir_acc_pkg::FIFO_AW-1:0]] <= i_data;
  end

endmodule

//--- design/apb_fir_acc.sv
`timescale 1ns/1ps

module apb_fir_acc (
  input  logic                           i_clk,
  input  logic                           i_reset,
  input  logic [fir_acc_pkg::ADDR_W-1:0] i_paddr,
  input  logic [31:0]                    i_pwdata,
  input  logic                           i_pwrite,
  input  logic                           i_psel,
  input  logic                           i_penable,
  output logic [31:0]                    o_prdata,
  output logic                           o_pready,
  output logic                           o_pslverr
);

  logic [fir_acc_pkg::RESULT_W-1:0] fifo_data;
  logic [fir_acc_pkg::RESULT_W-1:0] chain_result;
  logic                             fifo_empty;
  logic                             fifo_full;
  logic                             chain_valid;
  logic                             busy;
  logic                             pop;
  logic                             ce;
  logic                             flush;
  logic                             input_done;
  logic                             drain_done;

  fir_cfg_if cfg_bus ();

  // no wait states and no slave errors
  assign o_pready  = 1'b1;
  assign o_pslverr = 1'b0;

  apb_fir_regs u_regs (
    .i_clk(i_clk), .i_reset(i_reset), .i_paddr(i_paddr), .i_pwdata(i_pwdata),
    .i_pwrite(i_pwrite), .i_psel(i_psel), .i_penable(i_penable),
    .i_fifo_data(fifo_data), .i_fifo_empty(fifo_empty), .i_fifo_full(fifo_full),
    .i_busy(busy), .o_prdata(o_prdata), .o_pop(pop), .cfg(cfg_bus.src)
  );

  fir_seq_fsm u_fsm (
    .i_clk(i_clk), .i_reset(i_reset), .i_input_done(input_done),
    .i_drain_done(drain_done), .o_ce(ce), .o_flush(flush), .o_busy(busy),
    .cfg(cfg_bus.core)
  );

  fir_step_counter u_step_cnt (
    .i_clk(i_clk), .i_reset(i_reset), .i_ce(ce), .i_flush(flush),
    .o_input_done(input_done), .o_drain_done(drain_done), .cfg(cfg_bus.core)
  );

  fir_tap_chain u_tap_chain (
    .i_clk(i_clk), .i_reset(i_reset), .i_ce(ce), .i_flush(flush),
    .o_result(chain_result), .o_valid(chain_valid), .cfg(cfg_bus.core)
  );

  result_fifo u_fifo (
    .i_clk(i_clk), .i_reset(i_reset), .i_push(chain_valid), .i_data(chain_result),
    .i_pop(pop), .o_data(fifo_data), .o_empty(fifo_empty), .o_full(fifo_full)
  );

endmodule

//--- tb/apb_fir_asserts.sv
`timescale 1ns/1ps

module apb_fir_asserts (
  input logic                    i_clk,
  input logic                    i_reset,
  input logic                    i_pready,
  input logic                    i_pslverr,
  input logic                    i_fifo_empty,
  input logic                    i_fifo_full,
  input logic                    i_valid,
  input fir_acc_pkg::seq_state_t i_state
);

  // zero wait states, never an error response
  a_apb_const: assert property (@(posedge i_clk) disable iff (i_reset)
    i_pready && !i_pslverr)
    else $error("pready low or pslverr high");

  a_fifo_flags: assert property (@(posedge i_clk) disable iff (i_reset)
    !(i_fifo_empty && i_fifo_full))
    else $error("fifo empty and full at the same time");

  // back to back results only come out of the drain
  a_valid_pulse: assert property (@(posedge i_clk) disable iff (i_reset)
    (i_valid && (i_state != fir_acc_pkg::DRAIN)) |=> !i_valid)
    else $error("result valid held outside of drain");

endmodule

//--- tb/tb_apb_fir_acc.sv
`timescale 1ns/1ps

module tb_apb_fir_acc;

  logic                           clk;
  logic                           reset;
  logic [fir_acc_pkg::ADDR_W-1:0] paddr;
  logic [31:0]                    pwdata;
  logic                           pwrite;
  logic                           psel;
  logic                           penable;
  logic [31:0]                    prdata;
  logic                           pready;
  logic                           pslverr;

  int          taps_v [fir_acc_pkg::MAX_TAPS];
  int          xs [$];
  logic [31:0] exp_q [$];
  logic [31:0] act_q [$];
  string       cur_test;
  int          n_checks;
  int          n_errors;
  int          t_checks;
  int          t_errors;

  apb_fir_acc DUT (
    .i_clk(clk), .i_reset(reset), .i_paddr(paddr), .i_pwdata(pwdata),
    .i_pwrite(pwrite), .i_psel(psel), .i_penable(penable),
    .o_prdata(prdata), .o_pready(pready), .o_pslverr(pslverr)
  );

  bind apb_fir_acc apb_fir_asserts u_asserts (
    .i_clk(i_clk), .i_reset(i_reset), .i_pready(o_pready), .i_pslverr(o_pslverr),
    .i_fifo_empty(fifo_empty), .i_fifo_full(fifo_full), .i_valid(chain_valid),
    .i_state(u_fsm.state)
  );

  always #4 clk = ~clk;

  // one point of the full convolution with x zero outside the written samples
  function automatic int conv_point(input int n, input int nt);
    int sum;
    sum = 0;
    for (int k = 0; k < nt; k++)
    begin
      if ((n - k >= 0) && (n - k < xs.size()))
        sum += taps_v[k] * xs[n - k];
    end
    return sum;
  endfunction

  // setup then access phase, starting and ending 1 ns after a rising edge
  task automatic apb_access(input int word, input logic wr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    int stall;
    stall   = 0;
    paddr   = fir_acc_pkg::ADDR_W'(word * 4);
    pwrite  = wr;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    while (!pready && stall < 16)
    begin
      @(negedge clk);
      stall++;
    end
    if (!pready)
    begin
      $display("ERROR: APB transfer to word %0d never completed", word);
      n_errors++;
    end
    assert (pslverr === 1'b0)
    else
    begin
      $display("ERROR: %s, slave error on APB transfer to word %0d", cur_test, word);
      n_errors++;
    end
    rdata = prdata;
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input int word, input logic [31:0] data);
    logic [31:0] unused;
    apb_access(word, 1'b1, data, unused);
  endtask

  task automatic apb_read(input int word, output logic [31:0] data);
    apb_access(word, 1'b0, 32'd0, data);
  endtask

  task automatic expect_read(input int word, input logic [31:0] exp);
    logic [31:0] rd;
    exp_q.push_back(exp);
    apb_read(word, rd);
    act_q.push_back(rd);
  endtask

  task automatic program_taps();
    for (int k = 0; k < fir_acc_pkg::MAX_TAPS; k++)
    begin
      taps_v[k] = int'($urandom_range(4095)) - 2048;
      apb_write(fir_acc_pkg::ADDR_TAP0 + k, 32'(taps_v[k]));
    end
  endtask

  task automatic random_samples(input int len);
    xs.delete();
    repeat (len)
      xs.push_back(int'($urandom_range(4095)) - 2048);
  endtask

  // poll busy until the drain has finished
  task automatic wait_idle();
    logic [31:0] st;
    int          polls;
    polls = 0;
    apb_read(fir_acc_pkg::ADDR_STATUS, st);
    while (st[2] && polls < 64)
    begin
      apb_read(fir_acc_pkg::ADDR_STATUS, st);
      polls++;
    end
    if (st[2])
    begin
      $display("ERROR: %s, filter still busy after %0d status polls", cur_test, polls);
      n_errors++;
    end
  endtask

  task automatic run_signal(input int nt);
    apb_write(fir_acc_pkg::ADDR_NTAPS, 32'(nt));
    apb_write(fir_acc_pkg::ADDR_LENGTH, 32'(xs.size()));
    foreach (xs[i])
      apb_write(fir_acc_pkg::ADDR_SAMPLE, 32'(xs[i]));
    wait_idle();
  endtask

  task automatic read_results(input int nt, input int n_out);
    for (int n = 0; n < n_out; n++)
      expect_read(fir_acc_pkg::ADDR_RESULT, 32'(conv_point(n, nt)));
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    t_checks = n_checks;
    t_errors = n_errors;
  endtask

  task automatic end_test();
    int cycles;
    cycles = 0;
    while (act_q.size() > 0 && cycles < 8)
    begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (act_q.size() > 0 || exp_q.size() > 0)
    begin
      $display("ERROR: %s, read values and expected values went out of step", cur_test);
      n_errors++;
      act_q.delete();
      exp_q.delete();
    end
    $display("%s: %0d checks, %0d errors", cur_test, n_checks - t_checks,
             n_errors - t_errors);
  endtask

  // compare process
  initial
  begin : compare_results
    logic [31:0] e;
    logic [31:0] a;
    forever
    begin
      @(posedge clk);
      while (act_q.size() > 0 && exp_q.size() > 0)
      begin
        e = exp_q.pop_front();
        a = act_q.pop_front();
        n_checks++;
        assert (a === e)
        else
        begin
          $display("Mismatch in %s: expected %08h, actual %08h", cur_test, e, a);
          n_errors++;
        end
      end
    end
  end

  initial
  begin
    clk      = 1'b0;
    reset    = 1'b1;
    paddr    = '0;
    pwdata   = '0;
    pwrite   = 1'b0;
    psel     = 1'b0;
    penable  = 1'b0;
    n_checks = 0;
    n_errors = 0;
    cur_test = "reset";
    void'($urandom(72566));
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    @(posedge clk);
    #1;

    begin_test("register_access");
    expect_read(fir_acc_pkg::ADDR_STATUS, 32'd1);
    program_taps();
    for (int k = 0; k < fir_acc_pkg::MAX_TAPS; k++)
      expect_read(fir_acc_pkg::ADDR_TAP0 + k, 32'(taps_v[k]));
    apb_write(fir_acc_pkg::ADDR_NTAPS, 32'd5);
    expect_read(fir_acc_pkg::ADDR_NTAPS, 32'd5);
    apb_write(fir_acc_pkg::ADDR_LENGTH, 32'd300);
    expect_read(fir_acc_pkg::ADDR_LENGTH, 32'd300);
    expect_read(3, 32'hFFFF_FFFF);
    expect_read(20, 32'hFFFF_FFFF);
    end_test();

    // unit sample gives the taps back
    begin_test("impulse_response");
    program_taps();
    xs = {1};
    run_signal(8);
    read_results(8, 8);
    expect_read(fir_acc_pkg::ADDR_STATUS, 32'd1);
    end_test();

    begin_test("random_convolution");
    program_taps();
    random_samples(6);
    run_signal(5);
    read_results(5, 10);
    end_test();

    begin_test("tap_count_change");
    run_signal(3);
    read_results(3, 8);
    expect_read(fir_acc_pkg::ADDR_COUNT, 32'd13);
    end_test();

    // 19 results into 16 entries drop the last three
    begin_test("fifo_overflow");
    program_taps();
    random_samples(12);
    run_signal(8);
    expect_read(fir_acc_pkg::ADDR_STATUS, 32'd2);
    read_results(8, 16);
    expect_read(fir_acc_pkg::ADDR_STATUS, 32'd1);
    end_test();

    $display("total: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

//--- apb_fir_acc.f
design/fir_acc_pkg.sv
design/fir_cfg_if.sv
design/apb_fir_regs.sv
design/fir_seq_fsm.sv
design/fir_step_counter.sv
design/fir_tap_chain.sv
design/result_fifo.sv
design/apb_fir_acc.sv
tb/apb_fir_asserts.sv
tb/tb_apb_fir_acc.sv
